/* tb.f */
+incdir+.
vi_pkg.sv
vi_decoder.sv
vi_int_registers.sv
vi_bypass_ctrl.sv
vi_int_alu.sv
vi_mult_delay.sv
vi_writeback.sv
vi_core.sv
tb_vi_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --assert -j 0
TOP      = tb_vi_core
FILELIST = tb.f
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb_vi_model.svh */
// Reference model of the integer execution core: architectural registers and expected writes

// Architectural state, register zero stays zero
logic [`VI_XLEN-1:0] model_regs [32] = '{default: '0};

// Expected writes per destination register, oldest first
logic [`VI_XLEN-1:0] exp_q [32][$];

int model_writes = 0;
int seen_writes = 0;

task automatic model_accept(input logic [`VI_XLEN-1:0] w);
	logic [6:0]            opcode;
	logic [2:0]            f3;
	logic [6:0]            f7;
	logic [`VI_REG_AW-1:0] rd;
	logic [`VI_XLEN-1:0]   a;
	logic [`VI_XLEN-1:0]   b;
	logic [`VI_XLEN-1:0]   imm;
	logic [`VI_XLEN-1:0]   res;
	logic                  writes;
	opcode = w[6:0];
	rd = w[11:7];
	f3 = w[14:12];
	f7 = w[31:25];
	a = model_regs[w[19:15]];
	b = model_regs[w[24:20]];
	imm = {{(`VI_XLEN-12){w[31]}}, w[31:20]};
	writes = 1'b1;
	res = '0;
	if (opcode == `VI_OP_IMM && f3 == `VI_F3_ADD) begin
		res = a + imm;
	end else if (opcode == `VI_OP_REG) begin
		case ({f7, f3})
			{`VI_F7_BASE, `VI_F3_ADD}: res = a + b;
			{`VI_F7_SUB, `VI_F3_ADD}:  res = a - b;
			{`VI_F7_MUL, `VI_F3_ADD}:  res = a * b;
			{`VI_F7_BASE, `VI_F3_AND}: res = a & b;
			{`VI_F7_BASE, `VI_F3_OR}:  res = a | b;
			{`VI_F7_BASE, `VI_F3_XOR}: res = a ^ b;
			default:                   writes = 1'b0;
		endcase
	end else begin
		writes = 1'b0;
	end
	// Writes to x0 vanish
	if (writes && rd != '0) begin
		model_regs[rd] = res;
		exp_q[rd].push_back(res);
		model_writes++;
	end
endtask

/* tb_vi_core.sv */
// Testbench of the integer execution core: random instruction stream checked against a model
`timescale 1ns/10ps
`include "vi_cfg.svh"

module tb_vi_core;

	localparam int N_INSTR = 2000;
	localparam int CYCLE_LIMIT = N_INSTR * 10 + 200;

	logic           clk_i = 1'b0;
	logic           rst_n_i = 1'b0;
	logic           instr_valid_i = 1'b0;
	vi_pkg::instr_t instr_i = '0;
	logic           instr_ready_o;
	vi_pkg::rslt_t  wb_o;

	logic [31:0] lfsr = 32'h656c_bab7;
	logic        taken = 1'b0;
	logic        first_after_rst = 1'b0;
	int          gen_cnt = 0;
	int          accepted = 0;
	int          checks = 0;
	int          errors = 0;
	int          cycle_cnt = 0;

	`include "tb_vi_model.svh"

	vi_core dut0 (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.instr_ready_o (instr_ready_o),
		.wb_o          (wb_o)
	);

	initial begin
		forever #4 clk_i = ~clk_i;
	end

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
		return v;
	endfunction

	// Small register set so hazards are frequent, x0 one time in eight
	function automatic logic [`VI_REG_AW-1:0] pick_reg();
		logic [2:0] v;
		v = 3'(rand_bits(3));
		if (v == 3'd0) begin
			return '0;
		end
		return {3'b000, v[1:0]} + 5'd1;
	endfunction

	function automatic logic [31:0] gen_word();
		logic [3:0]            kind;
		logic [`VI_REG_AW-1:0] rd;
		logic [`VI_REG_AW-1:0] rs1;
		logic [`VI_REG_AW-1:0] rs2;
		logic [11:0]           imm;
		kind = 4'(rand_bits(4));
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		imm = 12'(rand_bits(12));
		case (kind)
			4'd0, 4'd1, 4'd15: return {`VI_F7_BASE, rs2, rs1, `VI_F3_ADD, rd, `VI_OP_REG};
			4'd2:              return {`VI_F7_SUB, rs2, rs1, `VI_F3_ADD, rd, `VI_OP_REG};
			4'd3:              return {`VI_F7_BASE, rs2, rs1, `VI_F3_AND, rd, `VI_OP_REG};
			4'd4:              return {`VI_F7_BASE, rs2, rs1, `VI_F3_OR, rd, `VI_OP_REG};
			4'd5:              return {`VI_F7_BASE, rs2, rs1, `VI_F3_XOR, rd, `VI_OP_REG};
			4'd6, 4'd7, 4'd8:  return {imm, rs1, `VI_F3_ADD, rd, `VI_OP_IMM};
			4'd9, 4'd10, 4'd11: return {`VI_F7_MUL, rs2, rs1, `VI_F3_ADD, rd, `VI_OP_REG};
			// Encodings outside the kept set
			4'd12:             return {7'b0000010, rs2, rs1, `VI_F3_ADD, rd, `VI_OP_REG};
			4'd13:             return {imm, rs1, 3'b001, rd, `VI_OP_IMM};
			default:           return rand_bits(32);
		endcase
	endfunction

	task automatic check_writeback(input vi_pkg::rslt_t wb);
		logic [`VI_XLEN-1:0] exp;
		checks++;
		seen_writes++;
		assert (wb.we && wb.rd != '0) else begin
			errors++;
			$display("Writeback marked valid without a register write (we=%0b rd=x%0d)",
				wb.we, wb.rd);
		end
		assert (exp_q[wb.rd].size() != 0) else begin
			errors++;
			$display("Unexpected writeback to x%0d with data %h", wb.rd, wb.data);
		end
		if (exp_q[wb.rd].size() != 0) begin
			exp = exp_q[wb.rd].pop_front();
			assert (wb.data == exp) else begin
				errors++;
				$display("[FAIL] writeback x%0d: expected %h, actual %h", wb.rd, exp, wb.data);
			end
		end
	endtask

	// Source side, a held word changes only after it is taken
	always @(posedge clk_i) begin
		if (rst_n_i && (!instr_valid_i || taken)) begin
			if (gen_cnt < N_INSTR && rand_bits(2) != 32'd0) begin
				instr_i <= gen_word();
				instr_valid_i <= 1'b1;
				gen_cnt++;
			end else begin
				instr_valid_i <= 1'b0;
			end
		end
	end

	// Observe between edges where inputs and outputs are settled
	always @(negedge clk_i) begin
		taken = 1'b0;
		if (!rst_n_i || first_after_rst) begin
			checks++;
			assert (!wb_o.valid && instr_ready_o) else begin
				errors++;
				$display("[FAIL] reset: expected valid=0 ready=1, actual valid=%0b ready=%0b",
					wb_o.valid, instr_ready_o);
			end
		end
		first_after_rst = !rst_n_i;
		if (rst_n_i) begin
			if (wb_o.valid) begin
				check_writeback(wb_o);
			end
			if (instr_valid_i && instr_ready_o) begin
				model_accept(instr_i);
				accepted++;
				taken = 1'b1;
			end
		end
	end

	initial begin
		while (cycle_cnt < CYCLE_LIMIT) begin
			@(posedge clk_i);
			cycle_cnt++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		repeat (4) @(posedge clk_i);
		rst_n_i <= 1'b1;
		while (accepted < N_INSTR || seen_writes < model_writes) begin
			@(posedge clk_i);
		end
		// Quiet window to catch stray writes still in the multiply line
		repeat (2 * `VI_MULT_STAGES + 4) @(posedge clk_i);
		for (int r = 0; r < 32; r++) begin
			assert (exp_q[r].size() == 0) else begin
				errors++;
				$display("Register x%0d ends with %0d writes that never retired",
					r, exp_q[r].size());
			end
		end
		checks++;
		assert (seen_writes == model_writes) else begin
			errors++;
			$display("[FAIL] write count: expected %0d, actual %0d", model_writes, seen_writes);
		end
		$display("Summary: %0d accepted, %0d writes, %0d checks, %0d errors",
			accepted, seen_writes, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

/* vi_core.sv */
// Integer execution core: decode, operand read with bypass, ALU, multiply delay and writeback
`timescale 1ns/10ps
`include "vi_cfg.svh"

module vi_core (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  logic               instr_valid_i,
	input  vi_pkg::instr_t     instr_i,
	output logic               instr_ready_o,
	output vi_pkg::rslt_t      wb_o
);

	vi_pkg::issue_t        dec_issue;
	logic [`VI_REG_AW-1:0] dec_rs1;
	logic [`VI_REG_AW-1:0] dec_rs2;
	logic [`VI_XLEN-1:0]   rf_data_a;
	logic [`VI_XLEN-1:0]   rf_data_b;
	logic [`VI_XLEN-1:0]   operand_a;
	logic [`VI_XLEN-1:0]   operand_b;
	logic                  stall;
	vi_pkg::rslt_t         exe_rslt;
	logic                  exe_is_mul;
	vi_pkg::mult_line_t    mult_line;

	vi_decoder decoder0 (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.instr_valid_i (instr_valid_i),
		.instr_i       (instr_i),
		.stall_i       (stall),
		.instr_ready_o (instr_ready_o),
		.rs1_o         (dec_rs1),
		.rs2_o         (dec_rs2),
		.issue_o       (dec_issue)
	);

	vi_int_registers int_registers0 (
		.clk_i    (clk_i),
		.rst_n_i  (rst_n_i),
		.rs1_i    (dec_rs1),
		.rs2_i    (dec_rs2),
		.wb_i     (wb_o),
		.data_a_o (rf_data_a),
		.data_b_o (rf_data_b)
	);

	vi_bypass_ctrl bypass_ctrl0 (
		.issue_i      (dec_issue),
		.data_a_i     (rf_data_a),
		.data_b_i     (rf_data_b),
		.exe_i        (exe_rslt),
		.exe_is_mul_i (exe_is_mul),
		.mult_i       (mult_line),
		.wb_i         (wb_o),
		.operand_a_o  (operand_a),
		.operand_b_o  (operand_b),
		.stall_o      (stall)
	);

	vi_int_alu int_alu0 (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.stall_i     (stall),
		.issue_i     (dec_issue),
		.operand_a_i (operand_a),
		.operand_b_i (operand_b),
		.rslt_o      (exe_rslt),
		.is_mul_o    (exe_is_mul)
	);

	vi_mult_delay mult_delay0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.exe_i        (exe_rslt),
		.exe_is_mul_i (exe_is_mul),
		.line_o       (mult_line)
	);

	vi_writeback writeback0 (
		.clk_i        (clk_i),
		.rst_n_i      (rst_n_i),
		.exe_i        (exe_rslt),
		.exe_is_mul_i (exe_is_mul),
		.mult_last_i  (mult_line[`VI_MULT_STAGES-1]),
		.wb_o         (wb_o)
	);

endmodule

/* vi_writeback.sv */
// Writeback latch: retires mult5 when it writes, otherwise the ALU result from execute
`timescale 1ns/10ps

module vi_writeback (
	input  logic          clk_i,
	input  logic          rst_n_i,
	input  vi_pkg::rslt_t exe_i,
	input  logic          exe_is_mul_i,
	input  vi_pkg::rslt_t mult_last_i,
	output vi_pkg::rslt_t wb_o
);

	logic          take_mult;
	logic          take_exe;
	logic          wb_valid_q;
	vi_pkg::rslt_t wb_pay_q;

	assign take_mult = mult_last_i.valid && mult_last_i.we;
	assign take_exe = exe_i.valid && exe_i.we && !exe_is_mul_i;

	// Only real register writes are presented as valid
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_valid_q <= 1'b0;
		end else begin
			wb_valid_q <= take_mult || take_exe;
		end
	end

	always_ff @(posedge clk_i) begin
		wb_pay_q <= take_mult ? mult_last_i : exe_i;
	end

	always_comb begin
		wb_o = wb_pay_q;
		wb_o.valid = wb_valid_q;
	end

endmodule

/* vi_mult_delay.sv */
// Multiply delay line: carries MUL results from execute through mult1 to mult5
`timescale 1ns/10ps
`include "vi_cfg.svh"

module vi_mult_delay (
	input  logic               clk_i,
	input  logic               rst_n_i,
	input  vi_pkg::rslt_t      exe_i,
	input  logic               exe_is_mul_i,
	output vi_pkg::mult_line_t line_o
);

	vi_pkg::mult_line_t line_q;
	vi_pkg::rslt_t      entry;

	// Non-MUL results take the short path and enter as bubbles here
	always_comb begin
		entry = exe_i;
		entry.valid = exe_i.valid && exe_is_mul_i;
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			line_q <= '0;
		end else begin
			line_q[0] <= entry;
			for (int i = 1; i < `VI_MULT_STAGES; i++) begin
				line_q[i] <= line_q[i-1];
			end
		end
	end

	assign line_o = line_q;

endmodule

/* vi_int_alu.sv */
// Execute stage: operand register and single-cycle ALU with 32-bit low product
`timescale 1ns/10ps
`include "vi_cfg.svh"

module vi_int_alu (
	input  logic                clk_i,
	input  logic                rst_n_i,
	input  logic                stall_i,
	input  vi_pkg::issue_t      issue_i,
	input  logic [`VI_XLEN-1:0] operand_a_i,
	input  logic [`VI_XLEN-1:0] operand_b_i,
	output vi_pkg::rslt_t       rslt_o,
	output logic                is_mul_o
);

	logic                exe_valid_q;
	vi_pkg::issue_t      exe_iss_q;
	logic [`VI_XLEN-1:0] opa_q;
	logic [`VI_XLEN-1:0] opb_q;
	logic [`VI_XLEN-1:0] result;

	// A stalled decode leaves a bubble behind it
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			exe_valid_q <= 1'b0;
		end else begin
			exe_valid_q <= issue_i.valid && !stall_i;
		end
	end

	always_ff @(posedge clk_i) begin
		exe_iss_q <= issue_i;
		opa_q <= operand_a_i;
		opb_q <= operand_b_i;
	end

	always_comb begin
		case (exe_iss_q.alu_op)
			vi_pkg::ALU_SUB: result = opa_q - opb_q;
			vi_pkg::ALU_AND: result = opa_q & opb_q;
			vi_pkg::ALU_OR:  result = opa_q | opb_q;
			vi_pkg::ALU_XOR: result = opa_q ^ opb_q;
			vi_pkg::ALU_MUL: result = opa_q * opb_q;
			default:         result = opa_q + opb_q;
		endcase
	end

	assign rslt_o = '{valid: exe_valid_q, we: exe_iss_q.we, rd: exe_iss_q.rd, data: result};
	assign is_mul_o = exe_iss_q.is_mul;

endmodule

/* vi_bypass_ctrl.sv */
// Operand forwarding from execute, the multiply line and writeback, plus hazard stall
`timescale 1ns/10ps
`include "vi_cfg.svh"

module vi_bypass_ctrl (
	input  vi_pkg::issue_t      issue_i,
	input  logic [`VI_XLEN-1:0] data_a_i,
	input  logic [`VI_XLEN-1:0] data_b_i,
	input  vi_pkg::rslt_t       exe_i,
	input  logic                exe_is_mul_i,
	input  vi_pkg::mult_line_t  mult_i,
	input  vi_pkg::rslt_t       wb_i,
	output logic [`VI_XLEN-1:0] operand_a_o,
	output logic [`VI_XLEN-1:0] operand_b_o,
	output logic                stall_o
);

	logic [`VI_XLEN-1:0] fwd_b;
	logic                alu_write;
	logic                waw;
	logic                wb_collision;
	logic                mul_raw;

	function automatic logic hit(input vi_pkg::rslt_t r, input logic [`VI_REG_AW-1:0] rs);
		return r.valid && r.we && (r.rd == rs);
	endfunction

	// Lowest priority is applied first, the newest writer last
	function automatic logic [`VI_XLEN-1:0] pick(
		input logic [`VI_REG_AW-1:0] rs,
		input logic [`VI_XLEN-1:0]   rf_data,
		input vi_pkg::rslt_t         exe,
		input logic                  exe_mul,
		input vi_pkg::mult_line_t    line,
		input vi_pkg::rslt_t         wb
	);
		logic [`VI_XLEN-1:0] val;
		val = rf_data;
		if (hit(wb, rs)) begin
			val = wb.data;
		end
		for (int i = `VI_MULT_STAGES - 1; i >= 0; i--) begin
			if (hit(line[i], rs)) begin
				val = line[i].data;
			end
		end
		if (!exe_mul && hit(exe, rs)) begin
			val = exe.data;
		end
		return val;
	endfunction

	assign operand_a_o = pick(issue_i.rs1, data_a_i, exe_i, exe_is_mul_i, mult_i, wb_i);
	assign fwd_b = pick(issue_i.rs2, data_b_i, exe_i, exe_is_mul_i, mult_i, wb_i);
	assign operand_b_o = issue_i.use_imm ? issue_i.imm : fwd_b;

	assign alu_write = issue_i.valid && issue_i.we && !issue_i.is_mul;

	// ALU op would overtake a MUL to the same register
	always_comb begin
		waw = exe_is_mul_i && hit(exe_i, issue_i.rd);
		for (int i = 0; i < `VI_MULT_STAGES - 1; i++) begin
			waw = waw || hit(mult_i[i], issue_i.rd);
		end
		waw = waw && alu_write;
	end

	// ALU op and mult5 would reach writeback in the same cycle
	assign wb_collision = alu_write && mult_i[`VI_MULT_STAGES-2].valid
		&& mult_i[`VI_MULT_STAGES-2].we;

	// MUL product is only forwarded once it sits in mult1
	assign mul_raw = issue_i.valid && exe_is_mul_i
		&& (hit(exe_i, issue_i.rs1) || hit(exe_i, issue_i.rs2));

	assign stall_o = waw || wb_collision || mul_raw;

endmodule

/* vi_int_registers.sv */
// Integer register file with two read ports and one write port, x0 hardwired to zero
`timescale 1ns/10ps
`include "vi_cfg.svh"

module vi_int_registers (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic [`VI_REG_AW-1:0] rs1_i,
	input  logic [`VI_REG_AW-1:0] rs2_i,
	input  vi_pkg::rslt_t         wb_i,
	output logic [`VI_XLEN-1:0]   data_a_o,
	output logic [`VI_XLEN-1:0]   data_b_o
);

	localparam int NREGS = 2 ** `VI_REG_AW;

	logic [`VI_XLEN-1:0] regs_q [1:NREGS-1];
	logic                write;

	assign write = wb_i.valid && wb_i.we && (wb_i.rd != '0);

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 1; i < NREGS; i++) begin
				regs_q[i] <= '0;
			end
		end else if (write) begin
			regs_q[wb_i.rd] <= wb_i.data;
		end
	end

	// Register zero has no storage
	assign data_a_o = (rs1_i == '0) ? '0 : regs_q[rs1_i];
	assign data_b_o = (rs2_i == '0) ? '0 : regs_q[rs2_i];

endmodule

/* vi_decoder.sv */
// Decode stage: holds the accepted instruction word and decodes it into an issue record
`timescale 1ns/10ps
`include "vi_cfg.svh"

module vi_decoder (
	input  logic                  clk_i,
	input  logic                  rst_n_i,
	input  logic                  instr_valid_i,
	input  vi_pkg::instr_t        instr_i,
	input  logic                  stall_i,
	output logic                  instr_ready_o,
	output logic [`VI_REG_AW-1:0] rs1_o,
	output logic [`VI_REG_AW-1:0] rs2_o,
	output vi_pkg::issue_t        issue_o
);

	logic           dec_valid_q;
	vi_pkg::instr_t dec_word_q;
	logic           accept;
	logic           legal;
	logic           use_imm;
	vi_pkg::alu_op_t op;

	// Stage can take a word when empty or when its content moves on
	assign instr_ready_o = !dec_valid_q || !stall_i;
	assign accept = instr_valid_i && instr_ready_o;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			dec_valid_q <= 1'b0;
		end else if (accept) begin
			dec_valid_q <= 1'b1;
		end else if (!stall_i) begin
			dec_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			dec_word_q <= instr_i;
		end
	end

	always_comb begin
		legal = 1'b0;
		use_imm = 1'b0;
		op = vi_pkg::ALU_ADD;
		case (dec_word_q.r.opcode)
			`VI_OP_REG: begin
				legal = 1'b1;
				case ({dec_word_q.r.funct7, dec_word_q.r.funct3})
					{`VI_F7_BASE, `VI_F3_ADD}: op = vi_pkg::ALU_ADD;
					{`VI_F7_SUB, `VI_F3_ADD}:  op = vi_pkg::ALU_SUB;
					{`VI_F7_MUL, `VI_F3_ADD}:  op = vi_pkg::ALU_MUL;
					{`VI_F7_BASE, `VI_F3_AND}: op = vi_pkg::ALU_AND;
					{`VI_F7_BASE, `VI_F3_OR}:  op = vi_pkg::ALU_OR;
					{`VI_F7_BASE, `VI_F3_XOR}: op = vi_pkg::ALU_XOR;
					default:                   legal = 1'b0;
				endcase
			end
			`VI_OP_IMM: begin
				// Only ADDI is kept from the immediate group
				legal = (dec_word_q.i.funct3 == `VI_F3_ADD);
				use_imm = 1'b1;
			end
			default: legal = 1'b0;
		endcase
	end

	// Unused or illegal sources read as x0 so they never cause a hazard
	assign rs1_o = legal ? dec_word_q.r.rs1 : '0;
	assign rs2_o = (legal && !use_imm) ? dec_word_q.r.rs2 : '0;

	always_comb begin
		issue_o.valid = dec_valid_q;
		issue_o.alu_op = op;
		issue_o.use_imm = use_imm;
		issue_o.imm = {{(`VI_XLEN-12){dec_word_q.i.imm12[11]}}, dec_word_q.i.imm12};
		issue_o.rs1 = rs1_o;
		issue_o.rs2 = rs2_o;
		issue_o.rd = dec_word_q.r.rd;
		issue_o.we = legal && (dec_word_q.r.rd != '0);
		issue_o.is_mul = (op == vi_pkg::ALU_MUL);
	end

endmodule

/* vi_pkg.sv */
// Shared types of the integer execution core: instruction views and stage records
`include "vi_cfg.svh"

package vi_pkg;

	// R-type field layout
	typedef struct packed {
		logic [6:0]            funct7;
		logic [`VI_REG_AW-1:0] rs2;
		logic [`VI_REG_AW-1:0] rs1;
		logic [2:0]            funct3;
		logic [`VI_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} r_type_t;

	// I-type field layout
	typedef struct packed {
		logic [11:0]           imm12;
		logic [`VI_REG_AW-1:0] rs1;
		logic [2:0]            funct3;
		logic [`VI_REG_AW-1:0] rd;
		logic [6:0]            opcode;
	} i_type_t;

	// One instruction word, read as R-type or I-type
	typedef union packed {
		r_type_t r;
		i_type_t i;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_MUL
	} alu_op_t;

	// Decoded instruction leaving the decode stage
	typedef struct packed {
		logic                  valid;
		alu_op_t               alu_op;
		logic                  use_imm;
		logic [`VI_XLEN-1:0]   imm;
		logic [`VI_REG_AW-1:0] rs1;
		logic [`VI_REG_AW-1:0] rs2;
		logic [`VI_REG_AW-1:0] rd;
		logic                  we;
		logic                  is_mul;
	} issue_t;

	// Result in flight towards the register file
	typedef struct packed {
		logic                  valid;
		logic                  we;
		logic [`VI_REG_AW-1:0] rd;
		logic [`VI_XLEN-1:0]   data;
	} rslt_t;

	// Index 0 is mult1, the last index is mult5
	typedef rslt_t [`VI_MULT_STAGES-1:0] mult_line_t;

endpackage

/* vi_cfg.svh */
// Configuration macros for the integer execution core: widths, depths and RV32 encodings
`ifndef VI_CFG_SVH
`define VI_CFG_SVH

// Datapath and instruction word width
`define VI_XLEN 32

// Register address width, 32 architectural registers
`define VI_REG_AW 5

// Number of delay stages behind execute for MUL results
`define VI_MULT_STAGES 5

// Major opcodes
`define VI_OP_REG 7'b0110011
`define VI_OP_IMM 7'b0010011

// funct3 values
`define VI_F3_ADD 3'b000
`define VI_F3_XOR 3'b100
`define VI_F3_OR 3'b110
`define VI_F3_AND 3'b111

// funct7 values
`define VI_F7_BASE 7'b0000000
`define VI_F7_SUB 7'b0100000
`define VI_F7_MUL 7'b0000001

`endif
